//--- hdl/mips_pkg.sv
// Shared field widths, data types, opcode, funct and ALU operation enums
package mips_pkg;

	// --------------------
	// Field widths
	// --------------------
	localparam int WORD_W    = 32;
	localparam int REG_IDX_W = 5;
	localparam int OPCODE_W  = 6;
	localparam int FUNCT_W   = 6;
	localparam int ALU_OP_W  = 3;
	localparam int IMM_W     = 16;

	// Data word and register index
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Primary opcodes, inst[31:26]
	typedef enum logic [OPCODE_W-1:0] {
		op_rtype = 6'h00,
		op_beq   = 6'h04,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_t;

	// R-type function codes, inst[5:0]
	typedef enum logic [FUNCT_W-1:0] {
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a
	} funct_t;

	// ALU operations, alu_add is the all-zero bubble value
	typedef enum logic [ALU_OP_W-1:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4
	} alu_op_t;

endpackage

//--- hdl/fetch_stage.sv
// Fetch stage: program counter with hold and branch redirect, IF/ID register with flush
`timescale 1ns/1ps

module fetch_stage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  logic            branch_taken,
	input  mips_pkg::word_t branch_target,
	input  mips_pkg::word_t imem_data,
	output mips_pkg::word_t imem_addr,
	output mips_pkg::word_t if_inst,
	output mips_pkg::word_t if_pc
);
	import mips_pkg::*;

	word_t pc;
	word_t pc_plus_4;

	// Sequential successor, also the link value for branch targets
	assign pc_plus_4 = pc + word_t'(4);

	// Instruction memory is read combinationally at the current PC
	assign imem_addr = pc;

	// --------------------
	// PC and IF/ID
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc      <= '0;
			if_inst <= '0;
			if_pc   <= '0;
		end
		else if (!stall)
		begin
			if (branch_taken)
			begin
				// Redirect, zero word in IF/ID squashes the wrong-path slot
				pc      <= branch_target;
				if_inst <= '0;
				if_pc   <= '0;
			end
			else
			begin
				pc      <= pc_plus_4;
				if_inst <= imem_data;
				if_pc   <= pc_plus_4;
			end
		end
		// Stall: PC and IF/ID hold
	end

endmodule

//--- hdl/reg_file.sv
// Register file: 32 words, two read ports with write bypass, reset to index values
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	input  logic               wr_en,
	input  mips_pkg::reg_idx_t wr_reg,
	input  mips_pkg::word_t    wr_data,
	output mips_pkg::word_t    data_1,
	output mips_pkg::word_t    data_2
);
	import mips_pkg::*;

	word_t regs [32];

	// Register i starts with value i
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= word_t'(i);
		end
		else if (wr_en && (wr_reg != '0))
			regs[wr_reg] <= wr_data;
	end

	// r0 hardwired, same-cycle write forwarded to readers
	assign data_1 = (rs == '0) ? '0 :
		(wr_en && (wr_reg == rs)) ? wr_data : regs[rs];
	assign data_2 = (rt == '0) ? '0 :
		(wr_en && (wr_reg == rt)) ? wr_data : regs[rt];

endmodule

//--- hdl/control_unit.sv
// Control unit: opcode and funct decode into pipeline control bits and illegal flag
`timescale 1ns/1ps

module control_unit (
	input  mips_pkg::word_t     inst,
	output mips_pkg::alu_op_t   alu_op,
	output logic                alu_src_imm,
	output logic                mem_read,
	output logic                mem_write,
	output logic                reg_write,
	output logic                dest_is_rd,
	output logic                branch,
	output logic                uses_rt,
	output logic                illegal
);
	import mips_pkg::*;

	always_comb
	begin
		// Defaults form a bubble
		alu_op      = alu_add;
		alu_src_imm = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		reg_write   = 1'b0;
		dest_is_rd  = 1'b0;
		branch      = 1'b0;
		uses_rt     = 1'b0;
		illegal     = 1'b0;

		// All-zero word is the nop left by flush and reset
		if (inst != '0)
		begin
			case (inst[31:26])
				op_rtype:
				begin
					reg_write  = 1'b1;
					dest_is_rd = 1'b1;
					uses_rt    = 1'b1;
					case (inst[5:0])
						fn_add: alu_op = alu_add;
						fn_sub: alu_op = alu_sub;
						fn_and: alu_op = alu_and;
						fn_or:  alu_op = alu_or;
						fn_slt: alu_op = alu_slt;
						default:
						begin
							// Unknown funct, drop back to a bubble
							reg_write  = 1'b0;
							dest_is_rd = 1'b0;
							uses_rt    = 1'b0;
							illegal    = 1'b1;
						end
					endcase
				end
				op_lw:
				begin
					alu_src_imm = 1'b1;
					mem_read    = 1'b1;
					reg_write   = 1'b1;
				end
				op_sw:
				begin
					// rt carries the store data
					alu_src_imm = 1'b1;
					mem_write   = 1'b1;
					uses_rt     = 1'b1;
				end
				op_beq:
				begin
					branch  = 1'b1;
					uses_rt = 1'b1;
				end
				default: illegal = 1'b1;
			endcase
		end
	end

endmodule

//--- hdl/hazard_unit.sv
// Hazard unit: RAW interlock of decode sources against EX and MEM destinations
`timescale 1ns/1ps

module hazard_unit (
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	input  logic               uses_rt,
	input  mips_pkg::reg_idx_t ex_dest,
	input  mips_pkg::reg_idx_t mem_dest,
	input  logic               ex_reg_write,
	input  logic               mem_reg_write,
	output logic               stall
);
	logic rs_hit;
	logic rt_hit;

	// r0 never carries a dependency
	assign rs_hit = (rs != '0) &&
		((ex_reg_write && (rs == ex_dest)) || (mem_reg_write && (rs == mem_dest)));
	// rt only matters for R-type, sw and beq
	assign rt_hit = uses_rt && (rt != '0) &&
		((ex_reg_write && (rt == ex_dest)) || (mem_reg_write && (rt == mem_dest)));

	// WB writes reach decode through the register file bypass
	assign stall = rs_hit || rt_hit;

endmodule

//--- hdl/decode_stage.sv
// Decode stage: field split, sign extension, beq resolve, ID/EX register, with its three units
`timescale 1ns/1ps

module decode_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  mips_pkg::word_t    if_inst,
	input  mips_pkg::word_t    if_pc,
	input  logic               wb_en,
	input  mips_pkg::reg_idx_t wb_reg,
	input  mips_pkg::word_t    wb_data,
	input  mips_pkg::reg_idx_t mem_dest,
	input  logic               mem_reg_write,
	output logic               stall,
	output logic               branch_taken,
	output logic               exception,
	output mips_pkg::word_t    branch_target,
	output logic               ex_valid,
	output mips_pkg::alu_op_t  ex_alu_op,
	output logic               ex_alu_src_imm,
	output logic               ex_mem_read,
	output logic               ex_mem_write,
	output logic               ex_reg_write,
	output mips_pkg::reg_idx_t ex_dest,
	output mips_pkg::word_t    ex_data_1,
	output mips_pkg::word_t    ex_data_2,
	output mips_pkg::word_t    ex_imm
);
	import mips_pkg::*;

	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	reg_idx_t dest;
	word_t    imm;
	word_t    data_1;
	word_t    data_2;
	alu_op_t  alu_op;
	logic     alu_src_imm;
	logic     mem_read;
	logic     mem_write;
	logic     reg_write;
	logic     dest_is_rd;
	logic     branch;
	logic     uses_rt;
	logic     illegal;
	logic     issue;

	// --------------------
	// Field split
	// --------------------
	assign rs  = if_inst[25:21];
	assign rt  = if_inst[20:16];
	assign rd  = if_inst[15:11];
	assign imm = {{(WORD_W - IMM_W){if_inst[IMM_W-1]}}, if_inst[IMM_W-1:0]};

	// R-type writes rd, lw writes rt
	assign dest = dest_is_rd ? rd : rt;

	reg_file i_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs      (rs),
		.rt      (rt),
		.wr_en   (wb_en),
		.wr_reg  (wb_reg),
		.wr_data (wb_data),
		.data_1  (data_1),
		.data_2  (data_2)
	);

	control_unit i_control_unit (
		.inst        (if_inst),
		.alu_op      (alu_op),
		.alu_src_imm (alu_src_imm),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.reg_write   (reg_write),
		.dest_is_rd  (dest_is_rd),
		.branch      (branch),
		.uses_rt     (uses_rt),
		.illegal     (illegal)
	);

	// EX side of the interlock comes from our own ID/EX register
	hazard_unit i_hazard_unit (
		.rs            (rs),
		.rt            (rt),
		.uses_rt       (uses_rt),
		.ex_dest       (ex_dest),
		.mem_dest      (mem_dest),
		.ex_reg_write  (ex_reg_write),
		.mem_reg_write (mem_reg_write),
		.stall         (stall)
	);

	// --------------------
	// Branch resolve
	// --------------------
	// Operands only trusted once the interlock has released
	assign branch_taken  = branch && !stall && (data_1 == data_2);
	// if_pc already holds pc+4
	assign branch_target = if_pc + {imm[WORD_W-3:0], 2'b00};

	// One pulse, raised on the cycle the instruction leaves decode
	assign exception = illegal && !stall;
	assign issue     = !stall && !illegal;

	// --------------------
	// ID/EX register
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n || !issue)
		begin
			// Bubble
			ex_valid       <= 1'b0;
			ex_alu_op      <= alu_add;
			ex_alu_src_imm <= 1'b0;
			ex_mem_read    <= 1'b0;
			ex_mem_write   <= 1'b0;
			ex_reg_write   <= 1'b0;
		end
		else
		begin
			ex_valid       <= 1'b1;
			ex_alu_op      <= alu_op;
			ex_alu_src_imm <= alu_src_imm;
			ex_mem_read    <= mem_read;
			ex_mem_write   <= mem_write;
			ex_reg_write   <= reg_write;
		end
	end

	// Operands and destination
	always_ff @(posedge clk)
	begin
		ex_dest   <= dest;
		ex_data_1 <= data_1;
		ex_data_2 <= data_2;
		ex_imm    <= imm;
	end

endmodule

//--- hdl/execute_stage.sv
// Execute stage: ALU, load/store address generation and the EX/MEM register
`timescale 1ns/1ps

module execute_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ex_valid,
	input  mips_pkg::alu_op_t  ex_alu_op,
	input  logic               ex_alu_src_imm,
	input  logic               ex_mem_read,
	input  logic               ex_mem_write,
	input  logic               ex_reg_write,
	input  mips_pkg::reg_idx_t ex_dest,
	input  mips_pkg::word_t    ex_data_1,
	input  mips_pkg::word_t    ex_data_2,
	input  mips_pkg::word_t    ex_imm,
	output logic               mem_mem_read,
	output logic               mem_mem_write,
	output logic               mem_reg_write,
	output mips_pkg::reg_idx_t mem_dest,
	output mips_pkg::word_t    mem_result,
	output mips_pkg::word_t    mem_store_data
);
	import mips_pkg::*;

	word_t alu_b;
	word_t alu_y;
	logic  lt_signed;

	// Second operand: rt value or the load/store offset
	assign alu_b = ex_alu_src_imm ? ex_imm : ex_data_2;

	assign lt_signed = $signed(ex_data_1) < $signed(alu_b);

	// --------------------
	// ALU
	// --------------------
	always_comb
	begin
		case (ex_alu_op)
			alu_add: alu_y = ex_data_1 + alu_b;
			alu_sub: alu_y = ex_data_1 - alu_b;
			alu_and: alu_y = ex_data_1 & alu_b;
			alu_or:  alu_y = ex_data_1 | alu_b;
			alu_slt: alu_y = {{(WORD_W - 1){1'b0}}, lt_signed};
			default: alu_y = ex_data_1 + alu_b;
		endcase
	end

	// --------------------
	// EX/MEM register
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mem_mem_read  <= 1'b0;
			mem_mem_write <= 1'b0;
			mem_reg_write <= 1'b0;
		end
		else
		begin
			// Only a live instruction carries side effects forward
			mem_mem_read  <= ex_valid && ex_mem_read;
			mem_mem_write <= ex_valid && ex_mem_write;
			mem_reg_write <= ex_valid && ex_reg_write;
		end
	end

	// Result, address and store data
	always_ff @(posedge clk)
	begin
		mem_dest       <= ex_dest;
		mem_result     <= alu_y;
		mem_store_data <= ex_data_2;
	end

endmodule

//--- hdl/memory_stage.sv
// Memory stage: word-addressed data memory, store report, write-back and retire outputs
`timescale 1ns/1ps

module memory_stage #(
	parameter int DMEM_WORDS = 64
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               mem_mem_read,
	input  logic               mem_mem_write,
	input  logic               mem_reg_write,
	input  mips_pkg::reg_idx_t mem_dest,
	input  mips_pkg::word_t    mem_result,
	input  mips_pkg::word_t    mem_store_data,
	output logic               wb_en,
	output mips_pkg::reg_idx_t wb_reg,
	output mips_pkg::word_t    wb_data,
	output logic               store_valid,
	output mips_pkg::word_t    store_addr,
	output mips_pkg::word_t    store_data
);
	import mips_pkg::*;

	localparam int ADDR_W = $clog2(DMEM_WORDS);

	word_t             dmem [DMEM_WORDS];
	logic [ADDR_W-1:0] dmem_idx;
	word_t             load_data;

	// Word index, byte offset bits dropped
	assign dmem_idx  = mem_result[ADDR_W+1:2];
	assign load_data = dmem[dmem_idx];

	// --------------------
	// Store path
	// --------------------
	always_ff @(posedge clk)
	begin
		if (mem_mem_write)
			dmem[dmem_idx] <= mem_store_data;
	end

	// Store visible in the cycle it writes
	assign store_valid = rst_n && mem_mem_write;
	assign store_addr  = mem_result;
	assign store_data  = mem_store_data;

	// --------------------
	// Write-back
	// --------------------
	// Register file written at the end of the memory cycle
	assign wb_en   = rst_n && mem_reg_write;
	assign wb_reg  = mem_dest;
	// lw takes memory data, everything else the ALU result
	assign wb_data = mem_mem_read ? load_data : mem_result;

endmodule

//--- hdl/mips_core.sv
// Core top level: fetch, decode, execute and memory stages wired in order
`timescale 1ns/1ps

module mips_core #(
	parameter int DMEM_WORDS = 64
) (
	input  logic               clk,
	input  logic               rst_n,
	input  mips_pkg::word_t    imem_data,
	output mips_pkg::word_t    imem_addr,
	output logic               retire_valid,
	output mips_pkg::reg_idx_t retire_reg,
	output mips_pkg::word_t    retire_data,
	output logic               store_valid,
	output mips_pkg::word_t    store_addr,
	output mips_pkg::word_t    store_data,
	output logic               exception
);
	import mips_pkg::*;

	// Fetch and decode
	word_t    if_inst, if_pc, branch_target;
	logic     stall, branch_taken;
	// ID/EX
	logic     ex_valid, ex_alu_src_imm, ex_mem_read, ex_mem_write, ex_reg_write;
	alu_op_t  ex_alu_op;
	reg_idx_t ex_dest;
	word_t    ex_data_1, ex_data_2, ex_imm;
	// EX/MEM
	logic     mem_mem_read, mem_mem_write, mem_reg_write;
	reg_idx_t mem_dest;
	word_t    mem_result, mem_store_data;

	fetch_stage i_fetch_stage (
		.clk (clk), .rst_n (rst_n), .stall (stall), .branch_taken (branch_taken),
		.branch_target (branch_target), .imem_data (imem_data),
		.imem_addr (imem_addr), .if_inst (if_inst), .if_pc (if_pc)
	);

	// MEM/WB outputs feed the register file and the retire port alike
	decode_stage i_decode_stage (
		.clk (clk), .rst_n (rst_n), .if_inst (if_inst), .if_pc (if_pc),
		.wb_en (retire_valid), .wb_reg (retire_reg), .wb_data (retire_data),
		.mem_dest (mem_dest), .mem_reg_write (mem_reg_write),
		.stall (stall), .branch_taken (branch_taken), .exception (exception),
		.branch_target (branch_target), .ex_valid (ex_valid), .ex_alu_op (ex_alu_op),
		.ex_alu_src_imm (ex_alu_src_imm), .ex_mem_read (ex_mem_read),
		.ex_mem_write (ex_mem_write), .ex_reg_write (ex_reg_write), .ex_dest (ex_dest),
		.ex_data_1 (ex_data_1), .ex_data_2 (ex_data_2), .ex_imm (ex_imm)
	);

	execute_stage i_execute_stage (
		.clk (clk), .rst_n (rst_n), .ex_valid (ex_valid), .ex_alu_op (ex_alu_op),
		.ex_alu_src_imm (ex_alu_src_imm), .ex_mem_read (ex_mem_read),
		.ex_mem_write (ex_mem_write), .ex_reg_write (ex_reg_write), .ex_dest (ex_dest),
		.ex_data_1 (ex_data_1), .ex_data_2 (ex_data_2), .ex_imm (ex_imm),
		.mem_mem_read (mem_mem_read), .mem_mem_write (mem_mem_write),
		.mem_reg_write (mem_reg_write), .mem_dest (mem_dest),
		.mem_result (mem_result), .mem_store_data (mem_store_data)
	);

	memory_stage #(
		.DMEM_WORDS (DMEM_WORDS)
	) i_memory_stage (
		.clk (clk), .rst_n (rst_n), .mem_mem_read (mem_mem_read),
		.mem_mem_write (mem_mem_write), .mem_reg_write (mem_reg_write),
		.mem_dest (mem_dest), .mem_result (mem_result), .mem_store_data (mem_store_data),
		.wb_en (retire_valid), .wb_reg (retire_reg), .wb_data (retire_data),
		.store_valid (store_valid), .store_addr (store_addr), .store_data (store_data)
	);

endmodule

//--- test/mips_core_sva.sv
// Bound concurrent assertions on the core's retire, store and exception outputs
`timescale 1ns/1ps

module mips_core_sva (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               retire_valid,
	input  mips_pkg::reg_idx_t retire_reg,
	input  mips_pkg::word_t    retire_data,
	input  logic               store_valid,
	input  mips_pkg::word_t    store_addr,
	input  mips_pkg::word_t    store_data,
	input  logic               exception
);

	// --------------------
	// Reset behavior
	// --------------------
	// Every reset edge leaves the outputs quiet
	a_quiet_after_reset: assert property (@(posedge clk)
		!rst_n |=> (!retire_valid && !store_valid && !exception))
		else $error("retire, store or exception active in the cycle after reset");

	// --------------------
	// Retire and exception
	// --------------------
	// r0 is never written, so it never retires
	a_retire_reg_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> (retire_reg != '0))
		else $error("retire_valid high with retire_reg zero");

	// Single pulse per illegal instruction
	a_exception_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		exception |=> !exception)
		else $error("exception held high for more than one cycle");

	// One instruction in the memory stage at a time
	a_retire_store_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(retire_valid && store_valid))
		else $error("retire_valid and store_valid high in the same cycle");

	// Event payloads fully known
	a_retire_known: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> !$isunknown({retire_reg, retire_data}))
		else $error("retire payload has unknown bits");

	a_store_known: assert property (@(posedge clk) disable iff (!rst_n)
		store_valid |-> !$isunknown({store_addr, store_data}))
		else $error("store payload has unknown bits");

endmodule

bind mips_core mips_core_sva i_mips_core_sva (
	.clk          (clk),
	.rst_n        (rst_n),
	.retire_valid (retire_valid),
	.retire_reg   (retire_reg),
	.retire_data  (retire_data),
	.store_valid  (store_valid),
	.store_addr   (store_addr),
	.store_data   (store_data),
	.exception    (exception)
);

//--- test/mips_core_tb.sv
// Testbench: clock, reset, program ROM, xorshift program generator, ISA model and checks
`timescale 1ns/1ps

module mips_core_tb;
	import mips_pkg::*;

	localparam int DMEM_WORDS   = 64;
	localparam int ROM_WORDS    = 256;
	localparam int NUM_TESTS    = 5;
	// Fetch sample to retire sample, through IF/ID, ID/EX and EX/MEM
	localparam int RETIRE_LAT   = 3;
	// Pipeline depth plus margin, catches late extra events
	localparam int DRAIN_CYCLES = 6;
	localparam int MAX_STEPS    = 1000;
	localparam logic [31:0] SEED = 32'h1f0c9f45;
	// beq r0,r0,-1 parks fetch past the program
	localparam word_t LOOP_INST = {op_beq, 5'd0, 5'd0, 16'hffff};

	logic     clk;
	logic     rst_n;
	word_t    imem_data;
	word_t    imem_addr;
	logic     retire_valid;
	reg_idx_t retire_reg;
	word_t    retire_data;
	logic     store_valid;
	word_t    store_addr;
	word_t    store_data;
	logic     exception;

	// Program and expected events
	word_t    rom [ROM_WORDS];
	int       prog_len;
	int       exp_pc [$];
	reg_idx_t exp_reg [$];
	word_t    exp_data [$];
	word_t    exp_st_addr [$];
	word_t    exp_st_data [$];
	int       exc_expected;
	int       exc_seen;

	// Run state
	string       cur_name;
	bit          latency_on;
	bit          running;
	int          test_errors;
	int          total_errors;
	int          n_pass;
	int          n_fail;
	int          cycle;
	int          fetch_cycle [ROM_WORDS];
	int          wd_count;
	int          wd_limit;
	logic [31:0] rng;

	mips_core #(
		.DMEM_WORDS (DMEM_WORDS)
	) i_mips_core (
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_data    (imem_data),
		.imem_addr    (imem_addr),
		.retire_valid (retire_valid),
		.retire_reg   (retire_reg),
		.retire_data  (retire_data),
		.store_valid  (store_valid),
		.store_addr   (store_addr),
		.store_data   (store_data),
		.exception    (exception)
	);

	// Combinational instruction ROM
	assign imem_data = (imem_addr[31:2] < prog_len) ? rom[imem_addr[9:2]] : LOOP_INST;

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------
	// Encoding and random helpers
	// --------------------
	function automatic word_t enc_r(input funct_t fn, input reg_idx_t rd,
		input reg_idx_t rs, input reg_idx_t rt);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t enc_i(input opcode_t op, input reg_idx_t rt,
		input reg_idx_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Next random value below n
	function automatic int pick(input int n);
		rng = xorshift(rng);
		return int'(rng % n);
	endfunction

	function automatic funct_t funct_of(input int k);
		case (k)
			0: return fn_add;
			1: return fn_sub;
			2: return fn_and;
			3: return fn_or;
			default: return fn_slt;
		endcase
	endfunction

	task automatic emit(input word_t w);
		rom[prog_len] = w;
		prog_len++;
	endtask

	// --------------------
	// Program generators
	// --------------------
	// Sources r1..r7 at reset values, results land in r8 upward
	task automatic gen_independent(input int count);
		int fn;
		int rs;
		int rt;
		for (int i = 0; i < count; i++)
		begin
			fn = pick(5);
			rs = 1 + pick(7);
			rt = 1 + pick(7);
			emit(enc_r(funct_of(fn), 8 + i, rs, rt));
		end
	endtask

	// Dense reuse of r1..r7; loads only from words already stored
	task automatic gen_chain(input int count);
		bit written [DMEM_WORDS];
		int kind;
		int slot;
		int fn;
		int rd;
		int rs;
		int rt;
		for (int i = 0; i < DMEM_WORDS; i++)
			written[i] = 1'b0;
		for (int i = 0; i < count; i++)
		begin
			kind = pick(8);
			slot = pick(DMEM_WORDS);
			fn   = pick(5);
			rd   = 1 + pick(7);
			rs   = 1 + pick(7);
			rt   = 1 + pick(7);
			if (kind == 0 || (kind == 1 && !written[slot]))
			begin
				emit(enc_i(op_sw, rt, 0, slot * 4));
				written[slot] = 1'b1;
			end
			else if (kind == 1)
				emit(enc_i(op_lw, rd, 0, slot * 4));
			else
				emit(enc_r(funct_of(fn), rd, rs, rt));
		end
	endtask

	task automatic build_program(input int id);
		prog_len   = 0;
		latency_on = 1'b0;
		case (id)
			1:
			begin
				cur_name   = "independent_rtype";
				latency_on = 1'b1;
				gen_independent(8);
			end
			2:
			begin
				cur_name = "dependent_chains";
				gen_chain(32);
			end
			3:
			begin
				cur_name = "store_load";
				emit(enc_i(op_sw, 5, 4, 8));
				emit(enc_i(op_lw, 6, 0, 12));
				// Negative offset off r16, base from reset value
				emit(enc_i(op_sw, 6, 16, -8));
				emit(enc_i(op_lw, 1, 4, 4));
				emit(enc_r(fn_add, 7, 1, 6));
			end
			4:
			begin
				cur_name = "branch";
				emit(enc_i(op_beq, 1, 1, 2));
				emit(enc_r(fn_add, 8, 1, 2));
				emit(enc_r(fn_add, 9, 1, 2));
				// Not taken, r1 != r2
				emit(enc_i(op_beq, 2, 1, 1));
				emit(enc_r(fn_add, 10, 3, 4));
				emit(enc_r(fn_sub, 11, 10, 1));
				// Taken only once r11 is current
				emit(enc_i(op_beq, 6, 11, 1));
				emit(enc_r(fn_or, 12, 1, 2));
				emit(enc_r(fn_and, 13, 7, 5));
			end
			default:
			begin
				cur_name = "illegal";
				emit(enc_r(fn_add, 8, 1, 2));
				emit({6'h3f, 5'd0, 5'd0, 16'h0123});
				emit(enc_r(fn_add, 9, 8, 3));
				// Bad funct, rs waits on r9 first
				emit({op_rtype, 5'd9, 5'd1, 5'd10, 5'd0, 6'h3f});
				emit(enc_r(fn_sub, 10, 9, 1));
				emit(enc_r(fn_or, 11, 10, 8));
				gen_chain(8);
			end
		endcase
		wd_limit = 20 * prog_len + 100;
	endtask

	// --------------------
	// ISA reference model
	// --------------------
	// Sequential execution of the ROM program into the expected lists
	task automatic run_model();
		word_t    regs [32];
		word_t    mem [DMEM_WORDS];
		word_t    inst;
		word_t    a;
		word_t    b;
		word_t    imm;
		word_t    res;
		word_t    addr;
		reg_idx_t dest;
		bit       writes;
		int       pc;
		int       next_pc;
		int       steps;
		exp_pc.delete();
		exp_reg.delete();
		exp_data.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		exc_expected = 0;
		for (int i = 0; i < 32; i++)
			regs[i] = word_t'(i);
		pc    = 0;
		steps = 0;
		while (pc < prog_len && steps < MAX_STEPS)
		begin
			inst    = rom[pc];
			a       = regs[inst[25:21]];
			b       = regs[inst[20:16]];
			imm     = {{16{inst[15]}}, inst[15:0]};
			dest    = inst[15:11];
			writes  = 1'b0;
			next_pc = pc + 1;
			case (inst[31:26])
				op_rtype:
				begin
					writes = 1'b1;
					case (inst[5:0])
						fn_add: res = a + b;
						fn_sub: res = a - b;
						fn_and: res = a & b;
						fn_or:  res = a | b;
						fn_slt: res = {31'd0, ($signed(a) < $signed(b))};
						default:
						begin
							writes = 1'b0;
							exc_expected++;
						end
					endcase
				end
				op_lw:
				begin
					addr   = a + imm;
					res    = mem[(addr >> 2) % DMEM_WORDS];
					dest   = inst[20:16];
					writes = 1'b1;
				end
				op_sw:
				begin
					addr = a + imm;
					mem[(addr >> 2) % DMEM_WORDS] = b;
					exp_st_addr.push_back(addr);
					exp_st_data.push_back(b);
				end
				op_beq:
				begin
					// Offset in words past pc+4
					if (a == b)
						next_pc = pc + 1 + int'($signed(imm));
				end
				default: exc_expected++;
			endcase
			if (writes && dest != '0)
			begin
				regs[dest] = res;
				exp_pc.push_back(pc);
				exp_reg.push_back(dest);
				exp_data.push_back(res);
			end
			pc = next_pc;
			steps++;
		end
	endtask

	// --------------------
	// Output checks
	// --------------------
	task check_retire();
		assert (exp_reg.size() > 0)
		else
		begin
			$display("ERROR: test %s retired r%0d = %h after the last expected retire",
				cur_name, retire_reg, retire_data);
			test_errors++;
		end
		if (exp_reg.size() > 0)
		begin
			assert (retire_reg == exp_reg[0] && retire_data == exp_data[0])
			else
			begin
				$display("MISMATCH test %s retire expected r%0d = %h actual r%0d = %h",
					cur_name, exp_reg[0], exp_data[0], retire_reg, retire_data);
				test_errors++;
			end
			if (latency_on)
			begin
				assert (cycle - fetch_cycle[exp_pc[0]] == RETIRE_LAT)
				else
				begin
					$display("MISMATCH test %s latency of pc %0h expected %0d actual %0d",
						cur_name, exp_pc[0] * 4, RETIRE_LAT, cycle - fetch_cycle[exp_pc[0]]);
					test_errors++;
				end
			end
			void'(exp_pc.pop_front());
			void'(exp_reg.pop_front());
			void'(exp_data.pop_front());
		end
	endtask

	task check_store();
		assert (exp_st_addr.size() > 0)
		else
		begin
			$display("ERROR: test %s stored %h at %h after the last expected store",
				cur_name, store_data, store_addr);
			test_errors++;
		end
		if (exp_st_addr.size() > 0)
		begin
			assert (store_addr == exp_st_addr[0] && store_data == exp_st_data[0])
			else
			begin
				$display("MISMATCH test %s store expected [%h] = %h actual [%h] = %h",
					cur_name, exp_st_addr[0], exp_st_data[0], store_addr, store_data);
				test_errors++;
			end
			void'(exp_st_addr.pop_front());
			void'(exp_st_data.pop_front());
		end
	endtask

	// Sampled mid-cycle, outputs settled since the rising edge
	always @(negedge clk)
	begin
		if (rst_n !== 1'b1)
			cycle = 0;
		else
			cycle = cycle + 1;
		fetch_cycle[imem_addr[9:2]] = cycle;
		if (rst_n === 1'b1)
		begin
			if (retire_valid)
				check_retire();
			if (store_valid)
				check_store();
			if (exception)
				exc_seen++;
		end
	end

	// Per-test watchdog
	always @(posedge clk)
	begin
		if (!running)
			wd_count = 0;
		else if (wd_count >= wd_limit)
		begin
			$display("TIMEOUT: test %s did not finish within %0d cycles", cur_name, wd_limit);
			$display("Test failures found");
			$finish;
		end
		else
			wd_count++;
	end

	// --------------------
	// Test sequencing
	// --------------------
	function automatic bit all_done();
		return exp_reg.size() == 0 && exp_st_addr.size() == 0 &&
			exc_seen >= exc_expected && imem_addr[31:2] >= prog_len;
	endfunction

	task automatic run_test(input int id);
		int n_ret;
		int n_st;
		@(negedge clk);
		rst_n <= 1'b0;
		// ROM and model change only while the core is held in reset
		@(posedge clk);
		build_program(id);
		run_model();
		n_ret       = exp_reg.size();
		n_st        = exp_st_addr.size();
		test_errors = 0;
		exc_seen    = 0;
		@(negedge clk);
		@(negedge clk);
		rst_n   <= 1'b1;
		running = 1'b1;
		@(posedge clk);
		while (!all_done())
			@(posedge clk);
		repeat (DRAIN_CYCLES) @(posedge clk);
		assert (exc_seen == exc_expected)
		else
		begin
			$display("MISMATCH test %s exceptions expected %0d actual %0d",
				cur_name, exc_expected, exc_seen);
			test_errors++;
		end
		@(negedge clk);
		running = 1'b0;
		total_errors += test_errors;
		if (test_errors == 0)
			n_pass++;
		else
			n_fail++;
		$display("test %-18s %s  retires %0d  stores %0d  exceptions %0d  errors %0d",
			cur_name, (test_errors == 0) ? "PASS" : "FAIL", n_ret, n_st, exc_expected,
			test_errors);
	endtask

	initial
	begin
		rst_n        = 1'b0;
		rng          = SEED;
		prog_len     = 0;
		running      = 1'b0;
		latency_on   = 1'b0;
		exc_seen     = 0;
		exc_expected = 0;
		test_errors  = 0;
		total_errors = 0;
		n_pass       = 0;
		n_fail       = 0;
		wd_limit     = 100;
		cur_name     = "reset";
		for (int t = 1; t <= NUM_TESTS; t++)
			run_test(t);
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
			NUM_TESTS, n_pass, n_fail, total_errors);
		if (n_fail == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- mips_core.f
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/control_unit.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_core.sv
test/mips_core_sva.sv
test/mips_core_tb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - hdl/mips_pkg.sv
  - hdl/fetch_stage.sv
  - hdl/reg_file.sv
  - hdl/control_unit.sv
  - hdl/hazard_unit.sv
  - hdl/decode_stage.sv
  - hdl/execute_stage.sv
  - hdl/memory_stage.sv
  - hdl/mips_core.sv
  - target: test
    files:
      - test/mips_core_sva.sv
      - test/mips_core_tb.sv
